// ==== include/lb_params.svh ====
`ifndef LB_PARAMS_SVH
`define LB_PARAMS_SVH

// Pixel and bus geometry
`define LB_PIX_W        8
`define LB_BUS_W        32
`define LB_PIX_PER_WORD 4

// Rows kept for the window column
`define LB_ROWS         3

// Row limits in pixels and in memory words
`define LB_MAX_ROW      1024
`define LB_RAM_DEPTH    256

`endif

// ==== verilog/lb_data_pkg.sv ====
`include "lb_params.svh"

package lb_data_pkg;

    // One pixel and one incoming bus word
    typedef logic [`LB_PIX_W-1:0] pixel_t;
    typedef logic [`LB_BUS_W-1:0] bus_word_t;

    // Pixel column index, also used for the row width
    typedef logic [$clog2(`LB_MAX_ROW)-1:0] pix_addr_t;

    // Word address inside one row memory
    typedef logic [$clog2(`LB_RAM_DEPTH)-1:0] word_addr_t;

    // Pixel position inside a bus word
    typedef logic [$clog2(`LB_PIX_PER_WORD)-1:0] lane_t;

    // Row memory index
    typedef logic [$clog2(`LB_ROWS)-1:0] row_sel_t;

endpackage

// ==== verilog/lb_ctrl_pkg.sv ====
package lb_ctrl_pkg;

    // Fill state of the line buffer
    // FILLING while at least one row is missing
    // READY once every row holds a complete line
    typedef enum logic {
        FILLING = 1'b0,
        READY   = 1'b1
    } fill_state_e;

endpackage

// ==== verilog/line_wr_if.sv ====
`include "lb_params.svh"

interface line_wr_if import lb_data_pkg::*; ();

    // Write strobe and data from the top level
    logic       wr_en;
    bus_word_t  wr_data;

    // Word address and end of row from the column counter
    word_addr_t wr_addr;
    logic       row_end;

    // Target row memory from the fill FSM
    row_sel_t   wr_row;

    modport counter (input wr_en, output wr_addr, output row_end);

    modport fsm (input wr_en, input row_end, output wr_row);

    modport store (input wr_en, input wr_data, input wr_addr, input wr_row);

endinterface

// ==== verilog/column_counter.sv ====
`include "lb_params.svh"

module column_counter import lb_data_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  pix_addr_t row_width,
    line_wr_if.counter wr
);

    word_addr_t last_word;

    // Last word of a row, row width given in pixels
    assign last_word = word_addr_t'(row_width / `LB_PIX_PER_WORD - 1);

    // Pulse while the final word of the row is written
    assign wr.row_end = wr.wr_en && (wr.wr_addr == last_word);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr.wr_addr <= '0;
        end else if (wr.wr_en) begin
            if (wr.row_end) begin
                wr.wr_addr <= '0;
            end else begin
                wr.wr_addr <= wr.wr_addr + word_addr_t'(1);
            end
        end
    end

endmodule

// ==== verilog/row_fill_fsm.sv ====
`include "lb_params.svh"

module row_fill_fsm
    import lb_data_pkg::*;
    import lb_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  pix_addr_t row_width,
    input  logic      r_en,
    input  pix_addr_t r_add,
    line_wr_if.fsm    wr,
    output logic      full
);

    fill_state_e      state;
    fill_state_e      state_next;
    logic [`LB_ROWS-1:0] row_valid;
    logic [`LB_ROWS-1:0] valid_next;
    logic             at_row_start;
    logic             wr_start;
    logic             rd_consume;
    pix_addr_t        last_pix;

    assign last_pix = row_width - pix_addr_t'(1);

    // First word of a row, matches word address 0 in the counter
    assign wr_start = wr.wr_en && at_row_start;

    // Reader takes the last pixel of the oldest row
    assign rd_consume = r_en && full && (r_add == last_pix);

    always_comb begin
        valid_next = row_valid;
        // Oldest row is the one at wr_row
        if (wr_start || rd_consume) begin
            valid_next[wr.wr_row] = 1'b0;
        end
        if (wr.row_end) begin
            valid_next[wr.wr_row] = 1'b1;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            FILLING: if (&valid_next) state_next = READY;
            READY:   if (!(&valid_next)) state_next = FILLING;
            default: state_next = FILLING;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= FILLING;
            row_valid    <= '0;
            wr.wr_row    <= '0;
            at_row_start <= 1'b1;
        end else begin
            state     <= state_next;
            row_valid <= valid_next;
            if (wr.row_end) begin
                at_row_start <= 1'b1;
                // Round robin over the row memories
                if (wr.wr_row == row_sel_t'(`LB_ROWS - 1)) begin
                    wr.wr_row <= '0;
                end else begin
                    wr.wr_row <= wr.wr_row + row_sel_t'(1);
                end
            end else if (wr.wr_en) begin
                at_row_start <= 1'b0;
            end
        end
    end

    assign full = (state == READY);

endmodule

// ==== verilog/row_ram.sv ====
module row_ram (
    input  logic                   clk,
    input  logic                   we,
    input  lb_data_pkg::word_addr_t wr_addr,
    input  lb_data_pkg::word_addr_t rd_addr,
    input  lb_data_pkg::bus_word_t  wr_data,
    input  logic                   re,
    output lb_data_pkg::bus_word_t  rd_data
);

    // One word per address value
    localparam int DEPTH = 2 ** $bits(lb_data_pkg::word_addr_t);

    lb_data_pkg::bus_word_t mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read port, data held until the next read
    always_ff @(posedge clk) begin
        if (re) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== verilog/line_store.sv ====
`include "lb_params.svh"

module line_store import lb_data_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                r_en,
    input  pix_addr_t           r_add,
    line_wr_if.store            wr,
    output pixel_t [`LB_ROWS-1:0] data_out,
    output logic                rd_valid
);

    word_addr_t rd_word;
    lane_t      rd_lane;
    lane_t      lane_q;
    row_sel_t   rot_q;
    bus_word_t  rd_words [`LB_ROWS];
    pixel_t     lane_pix [`LB_ROWS];

    // Split the pixel column into word address and lane
    assign rd_word = word_addr_t'(r_add / `LB_PIX_PER_WORD);
    assign rd_lane = lane_t'(r_add % `LB_PIX_PER_WORD);

    for (genvar g = 0; g < `LB_ROWS; g++) begin : g_row
        row_ram u_row_ram (
            .clk     (clk),
            .we      (wr.wr_en && (wr.wr_row == row_sel_t'(g))),
            .wr_addr (wr.wr_addr),
            .rd_addr (rd_word),
            .wr_data (wr.wr_data),
            .re      (r_en),
            .rd_data (rd_words[g])
        );

        assign lane_pix[g] = rd_words[g][lane_q*`LB_PIX_W +: `LB_PIX_W];
    end

    // Lane and rotation follow the memory read by one cycle
    always_ff @(posedge clk) begin
        if (r_en) begin
            lane_q <= rd_lane;
            rot_q  <= wr.wr_row;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= r_en;
        end
    end

    // Lane 0 is the oldest row, which is the next one to be written
    always_comb begin
        for (int i = 0; i < `LB_ROWS; i++) begin
            data_out[i] = lane_pix[(i + int'(rot_q)) % `LB_ROWS];
        end
    end

endmodule

// ==== verilog/line_buffer_top.sv ====
`include "lb_params.svh"

module line_buffer_top import lb_data_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  pix_addr_t             row_width,
    input  logic                  wr_en,
    input  bus_word_t             data_in,
    input  logic                  r_en,
    input  pix_addr_t             r_add,
    output pixel_t [`LB_ROWS-1:0] data_out,
    output logic                  rd_valid,
    output logic                  full
);

    // Write side bundle shared by all three blocks
    line_wr_if wr_bus ();

    assign wr_bus.wr_en   = wr_en;
    assign wr_bus.wr_data = data_in;

    column_counter u_column_counter (
        .clk       (clk),
        .rst       (rst),
        .row_width (row_width),
        .wr        (wr_bus.counter)
    );

    row_fill_fsm u_row_fill_fsm (
        .clk       (clk),
        .rst       (rst),
        .row_width (row_width),
        .r_en      (r_en),
        .r_add     (r_add),
        .wr        (wr_bus.fsm),
        .full      (full)
    );

    // Row memories and window column output
    line_store u_line_store (
        .clk      (clk),
        .rst      (rst),
        .r_en     (r_en),
        .r_add    (r_add),
        .wr       (wr_bus.store),
        .data_out (data_out),
        .rd_valid (rd_valid)
    );

endmodule

// ==== verif/lb_tb.sv ====
`include "lb_params.svh"

module lb_tb import lb_data_pkg::*; ();

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 10;
    localparam int SEED = 68421;
    localparam int READS = 20;
    localparam int POLL_LIMIT = 50;
    // Two resets, eight rows, four read bursts, two consuming reads, then margin
    localparam int RUN_CYCLES = 2 * (RESET_CYCLES + 1) + 5 * (16 / 4 + 1)
                              + 3 * (64 / 4 + 1) + 4 * (READS + 1) + 2 * 2 + 200;

    logic      clk;
    logic      rst;
    pix_addr_t row_width;
    logic      wr_en;
    bus_word_t data_in;
    logic      r_en;
    pix_addr_t r_add;
    pixel_t [`LB_ROWS-1:0] data_out;
    logic      rd_valid;
    logic      full;

    // Reference model state
    pixel_t    m_rows [`LB_ROWS][`LB_MAX_ROW];
    logic [`LB_ROWS-1:0] m_valid;
    int        m_row;
    int        m_addr;
    logic      exp_full;
    logic      exp_valid;
    pixel_t [`LB_ROWS-1:0] exp_data;

    line_buffer_top u_line_buffer_top (
        .clk       (clk),
        .rst       (rst),
        .row_width (row_width),
        .wr_en     (wr_en),
        .data_in   (data_in),
        .r_en      (r_en),
        .r_add     (r_add),
        .data_out  (data_out),
        .rd_valid  (rd_valid),
        .full      (full)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_failure(string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        report_failure($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    // Model of rows, write pointer and valid bits, one step per edge
    always @(posedge clk) begin
        logic [`LB_ROWS-1:0] valid_nx;
        int   last_word;
        logic row_done;
        logic overwrite;
        logic consume;
        if (rst) begin
            m_valid   <= '0;
            m_row     <= 0;
            m_addr    <= 0;
            exp_full  <= 1'b0;
            exp_valid <= 1'b0;
        end else begin
            last_word = row_width / `LB_PIX_PER_WORD - 1;
            row_done  = wr_en && (m_addr == last_word);
            overwrite = wr_en && (m_addr == 0) && m_valid[m_row];
            consume   = r_en && exp_full && (r_add == row_width - 1);
            valid_nx  = m_valid;
            if (overwrite || consume) begin
                valid_nx[m_row] = 1'b0;
            end
            if (row_done) begin
                valid_nx[m_row] = 1'b1;
            end
            // Oldest row sits at the write pointer
            if (r_en) begin
                for (int i = 0; i < `LB_ROWS; i++) begin
                    exp_data[i] <= m_rows[(i + m_row) % `LB_ROWS][r_add];
                end
            end
            if (wr_en) begin
                for (int j = 0; j < `LB_PIX_PER_WORD; j++) begin
                    m_rows[m_row][m_addr * `LB_PIX_PER_WORD + j] =
                        data_in[j * `LB_PIX_W +: `LB_PIX_W];
                end
                m_addr <= row_done ? 0 : m_addr + 1;
            end
            if (row_done) begin
                m_row <= (m_row + 1) % `LB_ROWS;
            end
            m_valid   <= valid_nx;
            exp_full  <= &valid_nx;
            exp_valid <= r_en;
        end
    end

    full_check: assert property (@(posedge clk) disable iff (rst) full == exp_full)
        else report_mismatch("full", $sampled(full), $sampled(exp_full));

    valid_check: assert property (@(posedge clk) disable iff (rst) rd_valid == exp_valid)
        else report_mismatch("rd_valid", $sampled(rd_valid), $sampled(exp_valid));

    data_check: assert property (@(posedge clk) disable iff (rst)
        rd_valid |-> data_out == exp_data)
        else report_mismatch("data_out", $sampled(data_out), $sampled(exp_data));

    task automatic apply_reset(pix_addr_t width);
        @(posedge clk);
        rst       <= 1'b1;
        row_width <= width;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic write_row();
        int words;
        words = row_width / `LB_PIX_PER_WORD;
        for (int w = 0; w < words; w++) begin
            @(posedge clk);
            wr_en   <= 1'b1;
            data_in <= bus_word_t'($urandom);
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    // Back to back reads, last pixel left out so full holds
    task automatic random_reads(int count);
        for (int n = 0; n < count; n++) begin
            @(posedge clk);
            r_en  <= 1'b1;
            r_add <= pix_addr_t'($urandom % (row_width - 1));
        end
        @(posedge clk);
        r_en <= 1'b0;
    endtask

    task automatic read_pixel(pix_addr_t addr);
        @(posedge clk);
        r_en  <= 1'b1;
        r_add <= addr;
        @(posedge clk);
        r_en <= 1'b0;
    endtask

    task automatic wait_for_full(logic level);
        int polls;
        polls = 0;
        while (full !== level) begin
            @(negedge clk);
            polls++;
            if (polls > POLL_LIMIT) begin
                report_failure($sformatf("full never reached %0b", level));
            end
        end
    endtask

    // Fill three rows, then read the window
    task automatic fill_and_read();
        write_row();
        write_row();
        write_row();
        wait_for_full(1'b1);
        random_reads(READS);
    endtask

    initial begin
        void'($urandom(SEED));
        rst       = 1'b1;
        row_width = pix_addr_t'(16);
        wr_en     = 1'b0;
        data_in   = '0;
        r_en      = 1'b0;
        r_add     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        fill_and_read();

        // Overwrite the two oldest rows in turn
        write_row();
        wait_for_full(1'b1);
        random_reads(READS);
        write_row();
        wait_for_full(1'b1);
        random_reads(READS);

        read_pixel(row_width - pix_addr_t'(1));
        wait_for_full(1'b0);

        apply_reset(pix_addr_t'(64));
        fill_and_read();
        read_pixel(row_width - pix_addr_t'(1));
        wait_for_full(1'b0);
        repeat (2) @(posedge clk);

        $display("ALL TESTS PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        report_failure($sformatf("Timeout after %0d cycles, the run did not finish", RUN_CYCLES));
    end

endmodule

// ==== list.f ====
+incdir+include
verilog/lb_data_pkg.sv
verilog/lb_ctrl_pkg.sv
verilog/line_wr_if.sv
verilog/column_counter.sv
verilog/row_fill_fsm.sv
verilog/row_ram.sv
verilog/line_store.sv
verilog/line_buffer_top.sv
verif/lb_tb.sv

// ==== Bender.yml ====
package:
  name: line_buffer

sources:
  - include_dirs:
      - include
    files:
      - verilog/lb_data_pkg.sv
      - verilog/lb_ctrl_pkg.sv
      - verilog/line_wr_if.sv
      - verilog/column_counter.sv
      - verilog/row_fill_fsm.sv
      - verilog/row_ram.sv
      - verilog/line_store.sv
      - verilog/line_buffer_top.sv
      - target: simulation
        files:
          - verif/lb_tb.sv
